/* term_pkg.sv */
`default_nettype none

package term_pkg;

   // terminal numbers seen on the upper half of the bus address
   localparam logic [15:0] TERM_LOOKUP_MAP = 16'h0021;
   localparam logic [15:0] TERM_CONTROL    = 16'h0022;

   // register selects inside the control terminal
   localparam logic [3:0] CTRL_REG_ENABLE  = 4'h0;
   localparam logic [3:0] CTRL_REG_TERM_ID = 4'h1;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus address, read as table index or as register select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef union packed {
      struct packed {
         logic [15:0] term;
         logic [7:0]  rsvd;
         logic [7:0]  index;
      } tbl;
      struct packed {
         logic [15:0] term;
         logic [11:0] rsvd;
         logic [3:0]  sel;
      } ctrl;
   } term_addr_u;

endpackage

`default_nettype wire

/* pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

   localparam int DTYPE_WIDTH = 4;
   localparam int META_WIDTH  = 16;

   // data-type codes carried with every beat
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_NONE        = 4'h0;
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_FRAME       = 4'h1;
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_FRAME_START = 4'h2;
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_FRAME_END   = 4'h3;
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_ROW_START   = 4'h4;
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_ROW_END     = 4'h5;
   // metadata beats, never remapped
   localparam logic [DTYPE_WIDTH-1:0] DTYPE_META        = 4'h8;

endpackage

`default_nettype wire

/* lut_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module lut_ram #(
   parameter int PIXEL_WIDTH = 8
) (
   input  wire logic                   di_clk,
   input  wire logic [PIXEL_WIDTH-1:0] tbl_addr,
   input  wire logic                   tbl_we,
   input  wire logic [PIXEL_WIDTH-1:0] tbl_wdata,
   output logic      [PIXEL_WIDTH-1:0] tbl_rdata,
   input  wire logic [PIXEL_WIDTH-1:0] pix_addr,
   output logic      [PIXEL_WIDTH-1:0] pix_data
);

   localparam int DEPTH = 2 ** PIXEL_WIDTH;

   logic [PIXEL_WIDTH-1:0] mem [DEPTH];

   // port a, bus side, read-first
   always_ff @(posedge di_clk) begin
      if (tbl_we) begin
         mem[tbl_addr] <= tbl_wdata;
      end
      tbl_rdata <= mem[tbl_addr];
   end

   // port b, pixel side
   // same-cycle write from port a still shows the old entry here
   always_ff @(posedge di_clk) begin
      pix_data <= mem[pix_addr];
   end

endmodule

`default_nettype wire

/* term_bus_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module term_bus_slave #(
   parameter int PIXEL_WIDTH   = 8,
   parameter int DI_DATA_WIDTH = 16
) (
   input  wire logic                     di_clk,
   input  wire logic                     resetb,
   input  wire logic                     wb_cyc,
   input  wire logic                     wb_stb,
   input  wire logic                     wb_we,
   input  wire logic [31:0]              wb_adr,
   input  wire logic [DI_DATA_WIDTH-1:0] wb_dat_w,
   output logic      [DI_DATA_WIDTH-1:0] wb_dat_r,
   output logic                          wb_ack,
   output logic                          wb_err,
   output logic      [PIXEL_WIDTH-1:0]   tbl_addr,
   output logic                          tbl_we,
   output logic      [PIXEL_WIDTH-1:0]   tbl_wdata,
   input  wire logic [PIXEL_WIDTH-1:0]   tbl_rdata,
   output logic                          map_enable
);

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_RESP = 1'b1;

   term_pkg::term_addr_u adr_u;

   logic       state;
   logic       start;
   logic       hit_tbl;
   logic       hit_ctrl;
   logic       acc_we;
   logic       acc_tbl;
   logic       acc_ctrl;
   logic [3:0] acc_sel;

   assign adr_u    = wb_adr;
   assign hit_tbl  = (adr_u.tbl.term == term_pkg::TERM_LOOKUP_MAP);
   assign hit_ctrl = (adr_u.ctrl.term == term_pkg::TERM_CONTROL);

   // hold off while the response is still on the bus
   assign start = (state == ST_IDLE) && wb_cyc && wb_stb && !wb_ack && !wb_err;

   // table access goes straight to port a in the first cycle
   assign tbl_addr  = PIXEL_WIDTH'(adr_u.tbl.index);
   assign tbl_we    = start && wb_we && hit_tbl;
   assign tbl_wdata = wb_dat_w[PIXEL_WIDTH-1:0];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // access sequencer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         state      <= ST_IDLE;
         acc_we     <= 1'b0;
         acc_tbl    <= 1'b0;
         acc_ctrl   <= 1'b0;
         acc_sel    <= 4'h0;
         map_enable <= 1'b0;
         wb_ack     <= 1'b0;
         wb_err     <= 1'b0;
         wb_dat_r   <= '0;
      end else begin
         wb_ack <= 1'b0;
         wb_err <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state    <= ST_RESP;
                  acc_we   <= wb_we;
                  acc_tbl  <= hit_tbl;
                  acc_ctrl <= hit_ctrl;
                  acc_sel  <= adr_u.ctrl.sel;
                  if (wb_we && hit_ctrl && adr_u.ctrl.sel == term_pkg::CTRL_REG_ENABLE) begin
                     map_enable <= wb_dat_w[0];
                  end
               end
            end
            ST_RESP: begin
               state    <= ST_IDLE;
               wb_ack   <= acc_tbl || acc_ctrl;
               wb_err   <= !(acc_tbl || acc_ctrl);
               wb_dat_r <= '0;
               if (!acc_we && acc_tbl) begin
                  wb_dat_r <= DI_DATA_WIDTH'(tbl_rdata);
               end else if (!acc_we && acc_ctrl) begin
                  if (acc_sel == term_pkg::CTRL_REG_ENABLE) begin
                     wb_dat_r <= DI_DATA_WIDTH'(map_enable);
                  end else if (acc_sel == term_pkg::CTRL_REG_TERM_ID) begin
                     wb_dat_r <= DI_DATA_WIDTH'(term_pkg::TERM_LOOKUP_MAP);
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* lookup_map.sv */
`timescale 1ns/1ns
`default_nettype none

module lookup_map #(
   parameter int PIXEL_WIDTH = 8
) (
   input  wire logic                                 di_clk,
   input  wire logic                                 resetb,
   input  wire logic                                 map_enable,
   input  wire logic                                 dvi,
   input  wire logic        [pixel_pkg::DTYPE_WIDTH-1:0] dtypei,
   input  wire logic        [PIXEL_WIDTH-1:0]        y,
   input  wire logic signed [PIXEL_WIDTH-1:0]        u,
   input  wire logic signed [PIXEL_WIDTH-1:0]        v,
   input  wire logic        [pixel_pkg::META_WIDTH-1:0] meta_datai,
   output logic             [PIXEL_WIDTH-1:0]        pix_addr,
   input  wire logic        [PIXEL_WIDTH-1:0]        pix_data,
   output logic                                      dvo,
   output logic             [pixel_pkg::DTYPE_WIDTH-1:0] dtypeo,
   output logic             [PIXEL_WIDTH-1:0]        yo,
   output logic signed      [PIXEL_WIDTH-1:0]        uo,
   output logic signed      [PIXEL_WIDTH-1:0]        vo,
   output logic             [pixel_pkg::META_WIDTH-1:0] meta_datao
);

   logic                              dv_s1;
   logic                              sel_s1;
   logic [pixel_pkg::DTYPE_WIDTH-1:0] dtype_s1;
   logic [PIXEL_WIDTH-1:0]            y_s1;
   logic signed [PIXEL_WIDTH-1:0]     u_s1;
   logic signed [PIXEL_WIDTH-1:0]     v_s1;
   logic [pixel_pkg::META_WIDTH-1:0]  meta_s1;

   // table lookup starts from the raw input
   assign pix_addr = y;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stage one, wait for the table read
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         dv_s1    <= 1'b0;
         sel_s1   <= 1'b0;
         dtype_s1 <= '0;
         y_s1     <= '0;
         u_s1     <= '0;
         v_s1     <= '0;
         meta_s1  <= '0;
      end else begin
         dv_s1    <= dvi;
         // only frame data is remapped
         sel_s1   <= map_enable && (dtypei == pixel_pkg::DTYPE_FRAME);
         dtype_s1 <= dtypei;
         y_s1     <= y;
         u_s1     <= u;
         v_s1     <= v;
         meta_s1  <= meta_datai;
      end
   end

   // stage two, pick mapped or original y
   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         dtypeo     <= '0;
         yo         <= '0;
         uo         <= '0;
         vo         <= '0;
         meta_datao <= '0;
      end else begin
         dvo        <= dv_s1;
         dtypeo     <= dtype_s1;
         yo         <= sel_s1 ? pix_data : y_s1;
         uo         <= u_s1;
         vo         <= v_s1;
         meta_datao <= meta_s1;
      end
   end

endmodule

`default_nettype wire

/* pixel_lut_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_lut_top #(
   parameter int PIXEL_WIDTH   = 8,
   parameter int DI_DATA_WIDTH = 16
) (
   input  wire logic                                 di_clk,
   input  wire logic                                 resetb,
   input  wire logic                                 wb_cyc,
   input  wire logic                                 wb_stb,
   input  wire logic                                 wb_we,
   input  wire logic        [31:0]                   wb_adr,
   input  wire logic        [DI_DATA_WIDTH-1:0]      wb_dat_w,
   output logic             [DI_DATA_WIDTH-1:0]      wb_dat_r,
   output logic                                      wb_ack,
   output logic                                      wb_err,
   input  wire logic                                 dvi,
   input  wire logic        [pixel_pkg::DTYPE_WIDTH-1:0] dtypei,
   input  wire logic        [PIXEL_WIDTH-1:0]        y,
   input  wire logic signed [PIXEL_WIDTH-1:0]        u,
   input  wire logic signed [PIXEL_WIDTH-1:0]        v,
   input  wire logic        [pixel_pkg::META_WIDTH-1:0] meta_datai,
   output logic                                      dvo,
   output logic             [pixel_pkg::DTYPE_WIDTH-1:0] dtypeo,
   output logic             [PIXEL_WIDTH-1:0]        yo,
   output logic signed      [PIXEL_WIDTH-1:0]        uo,
   output logic signed      [PIXEL_WIDTH-1:0]        vo,
   output logic             [pixel_pkg::META_WIDTH-1:0] meta_datao
);

   logic [PIXEL_WIDTH-1:0] tbl_addr;
   logic                   tbl_we;
   logic [PIXEL_WIDTH-1:0] tbl_wdata;
   logic [PIXEL_WIDTH-1:0] tbl_rdata;
   logic [PIXEL_WIDTH-1:0] pix_addr;
   logic [PIXEL_WIDTH-1:0] pix_data;
   logic                   map_enable;

   // bus decode and control register
   term_bus_slave #(
      .PIXEL_WIDTH   (PIXEL_WIDTH),
      .DI_DATA_WIDTH (DI_DATA_WIDTH)
   ) term_bus_slave_i (
      .di_clk     (di_clk),
      .resetb     (resetb),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .wb_err     (wb_err),
      .tbl_addr   (tbl_addr),
      .tbl_we     (tbl_we),
      .tbl_wdata  (tbl_wdata),
      .tbl_rdata  (tbl_rdata),
      .map_enable (map_enable)
   );

   lut_ram #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) lut_ram_i (
      .di_clk    (di_clk),
      .tbl_addr  (tbl_addr),
      .tbl_we    (tbl_we),
      .tbl_wdata (tbl_wdata),
      .tbl_rdata (tbl_rdata),
      .pix_addr  (pix_addr),
      .pix_data  (pix_data)
   );

   // y remap, two cycles through
   lookup_map #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) lookup_map_i (
      .di_clk     (di_clk),
      .resetb     (resetb),
      .map_enable (map_enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .y          (y),
      .u          (u),
      .v          (v),
      .meta_datai (meta_datai),
      .pix_addr   (pix_addr),
      .pix_data   (pix_data),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .yo         (yo),
      .uo         (uo),
      .vo         (vo),
      .meta_datao (meta_datao)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD = 4
) (
   output logic di_clk,
   output logic resetb
);

   initial begin
      di_clk = 1'b0;
      forever #HALF_PERIOD di_clk = ~di_clk;
   end

   // reset held over two rising edges
   initial begin
      resetb = 1'b0;
      repeat (2) @(posedge di_clk);
      #1;
      resetb = 1'b1;
   end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
   parameter int PIXEL_WIDTH   = 8,
   parameter int DI_DATA_WIDTH = 16
) (
   input  wire logic                              di_clk,
   input  wire logic                              resetb,
   input  wire logic                              wb_cyc,
   input  wire logic                              wb_stb,
   input  wire logic                              wb_we,
   input  wire logic [31:0]                       wb_adr,
   input  wire logic [DI_DATA_WIDTH-1:0]          wb_dat_w,
   input  wire logic [DI_DATA_WIDTH-1:0]          wb_dat_r,
   input  wire logic                              wb_ack,
   input  wire logic                              wb_err,
   input  wire logic                              dvi,
   input  wire logic [pixel_pkg::DTYPE_WIDTH-1:0] dtypei,
   input  wire logic [PIXEL_WIDTH-1:0]            y,
   input  wire logic [PIXEL_WIDTH-1:0]            u,
   input  wire logic [PIXEL_WIDTH-1:0]            v,
   input  wire logic [pixel_pkg::META_WIDTH-1:0]  meta_datai,
   input  wire logic                              dvo,
   input  wire logic [pixel_pkg::DTYPE_WIDTH-1:0] dtypeo,
   input  wire logic [PIXEL_WIDTH-1:0]            yo,
   input  wire logic [PIXEL_WIDTH-1:0]            uo,
   input  wire logic [PIXEL_WIDTH-1:0]            vo,
   input  wire logic [pixel_pkg::META_WIDTH-1:0]  meta_datao,
   output int                                     error_count
);

   localparam int EW = 2 + pixel_pkg::DTYPE_WIDTH + 3 * PIXEL_WIDTH + pixel_pkg::META_WIDTH;

   logic [PIXEL_WIDTH-1:0]   table_m [2 ** PIXEL_WIDTH];
   logic                     enable_m;
   logic [EW-1:0]            exp_q [$];
   int                       wait_cnt;
   int                       fail_count = 0;
   logic                     req_we;
   term_pkg::term_addr_u     req_adr;
   logic [DI_DATA_WIDTH-1:0] req_dat;

   assign error_count = fail_count;

   task automatic check_value(input string name, input logic [31:0] expv,
                              input logic [31:0] act);
      if (act !== expv) begin
         fail_count++;
         $display("[FAIL] %s: expected %0h, actual %0h", name, expv, act);
      end
   endtask

   task automatic report_fault(input string what);
      fail_count++;
      $display("bus fault: %s", what);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pixel model, outputs after edge n carry the pixel of edge n-1
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_pixel();
      logic                              e_map;
      logic                              e_dv;
      logic [pixel_pkg::DTYPE_WIDTH-1:0] e_dtype;
      logic [PIXEL_WIDTH-1:0]            e_y;
      logic [PIXEL_WIDTH-1:0]            e_u;
      logic [PIXEL_WIDTH-1:0]            e_v;
      logic [pixel_pkg::META_WIDTH-1:0]  e_meta;
      logic                              map_now;
      {e_map, e_dv, e_dtype, e_y, e_u, e_v, e_meta} = exp_q.pop_front();
      check_value("dvo", 32'(e_dv), 32'(dvo));
      check_value("dtypeo", 32'(e_dtype), 32'(dtypeo));
      check_value(e_map ? "yo mapped" : "yo passthrough", 32'(e_y), 32'(yo));
      check_value("uo", 32'(e_u), 32'(uo));
      check_value("vo", 32'(e_v), 32'(vo));
      check_value("meta_datao", 32'(e_meta), 32'(meta_datao));
      map_now = enable_m && (dtypei == pixel_pkg::DTYPE_FRAME);
      exp_q.push_back({map_now, dvi, dtypei, map_now ? table_m[y] : y, u, v, meta_datai});
   endtask

   task automatic check_response();
      logic known;
      known = (req_adr.tbl.term == term_pkg::TERM_LOOKUP_MAP) ||
              (req_adr.tbl.term == term_pkg::TERM_CONTROL);
      if (!known) begin
         if (wb_ack) report_fault("ack returned for an unknown terminal");
         check_value("unknown terminal read data", 32'h0, 32'(wb_dat_r));
      end else begin
         if (wb_err) report_fault("err returned for a known terminal");
         if (req_adr.tbl.term == term_pkg::TERM_LOOKUP_MAP) begin
            if (req_we) table_m[req_adr.tbl.index] = req_dat[PIXEL_WIDTH-1:0];
            else check_value("table readback", 32'(table_m[req_adr.tbl.index]), 32'(wb_dat_r));
         end else if (req_adr.ctrl.sel == term_pkg::CTRL_REG_ENABLE) begin
            if (req_we) enable_m = req_dat[0];
            else check_value("enable readback", 32'(enable_m), 32'(wb_dat_r));
         end else if (req_adr.ctrl.sel == term_pkg::CTRL_REG_TERM_ID && !req_we) begin
            check_value("terminal id", 32'(term_pkg::TERM_LOOKUP_MAP), 32'(wb_dat_r));
         end
      end
   endtask

   // bus side, the response must follow two cycles of held request
   task automatic check_bus();
      if (wb_ack && wb_err) report_fault("ack and err raised in the same cycle");
      if (wb_ack || wb_err) begin
         if (wait_cnt == 0) begin
            report_fault("response without a pending request");
         end else begin
            if (wait_cnt != 2) report_fault("response did not come 2 cycles after the request");
            check_response();
         end
         wait_cnt = 0;
      end else if (wb_cyc && wb_stb) begin
         if (wait_cnt == 0) begin
            req_we  = wb_we;
            req_adr = wb_adr;
            req_dat = wb_dat_w;
         end
         wait_cnt++;
         if (wait_cnt == 3) report_fault("no response to a bus request");
      end
   endtask

   always @(negedge di_clk) begin
      if (!resetb) begin
         wait_cnt = 0;
         enable_m = 1'b0;
         exp_q.delete();
         exp_q.push_back('0);
         exp_q.push_back('0);
      end else begin
         check_pixel();
         check_bus();
      end
   end

endmodule

`default_nettype wire

/* tb_pixel_lut_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pixel_lut_top;

   localparam int PIXEL_WIDTH   = 8;
   localparam int DI_DATA_WIDTH = 16;
   localparam int N_RW          = 8;
   localparam int N_PHASE_PIX   = 200;
   localparam int N_BUS         = 1 + 256 + 2 * N_RW + 10;
   localparam int N_PIX         = 3 * N_PHASE_PIX + 8;
   localparam int MARGIN        = 8;

   logic                              di_clk;
   logic                              resetb;
   logic                              wb_cyc;
   logic                              wb_stb;
   logic                              wb_we;
   logic [31:0]                       wb_adr;
   logic [DI_DATA_WIDTH-1:0]          wb_dat_w;
   logic [DI_DATA_WIDTH-1:0]          wb_dat_r;
   logic                              wb_ack;
   logic                              wb_err;
   logic                              dvi;
   logic [pixel_pkg::DTYPE_WIDTH-1:0] dtypei;
   logic [PIXEL_WIDTH-1:0]            y;
   logic [PIXEL_WIDTH-1:0]            u;
   logic [PIXEL_WIDTH-1:0]            v;
   logic [pixel_pkg::META_WIDTH-1:0]  meta_datai;
   logic                              dvo;
   logic [pixel_pkg::DTYPE_WIDTH-1:0] dtypeo;
   logic [PIXEL_WIDTH-1:0]            yo;
   logic [PIXEL_WIDTH-1:0]            uo;
   logic [PIXEL_WIDTH-1:0]            vo;
   logic [pixel_pkg::META_WIDTH-1:0]  meta_datao;
   int                                error_count;
   logic [15:0]                       lfsr = 16'd60;

   tb_clock_gen clock_gen_i (.di_clk(di_clk), .resetb(resetb));

   pixel_lut_top #(
      .PIXEL_WIDTH   (PIXEL_WIDTH),
      .DI_DATA_WIDTH (DI_DATA_WIDTH)
   ) pixel_lut_top_i (.*);

   tb_checker #(
      .PIXEL_WIDTH   (PIXEL_WIDTH),
      .DI_DATA_WIDTH (DI_DATA_WIDTH)
   ) checker_i (.*);

   // galois lfsr, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   task automatic set_pixels_idle();
      dvi        = 1'b0;
      dtypei     = pixel_pkg::DTYPE_NONE;
      y          = '0;
      u          = '0;
      v          = '0;
      meta_datai = '0;
   endtask

   task automatic bus_access(input logic we, input logic [31:0] adr,
                             input logic [DI_DATA_WIDTH-1:0] dat);
      @(posedge di_clk);
      #1;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      do begin
         @(posedge di_clk);
         #1;
      end while (!wb_ack && !wb_err);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic stream_pixels(input int n);
      logic [3:0] code;
      repeat (n) begin
         @(posedge di_clk);
         #1;
         dvi = 1'(take_bits(1));
         if (take_bits(2) != 0) begin
            dtypei = pixel_pkg::DTYPE_FRAME;
         end else begin
            code   = 4'(take_bits(4));
            dtypei = (code == pixel_pkg::DTYPE_FRAME) ? pixel_pkg::DTYPE_META : code;
         end
         y          = PIXEL_WIDTH'(take_bits(PIXEL_WIDTH));
         u          = PIXEL_WIDTH'(take_bits(PIXEL_WIDTH));
         v          = PIXEL_WIDTH'(take_bits(PIXEL_WIDTH));
         meta_datai = 16'(take_bits(16));
      end
      @(posedge di_clk);
      #1;
      set_pixels_idle();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      logic [31:0] ctrl_en;
      logic [31:0] adr;
      logic [15:0] term;
      ctrl_en  = {term_pkg::TERM_CONTROL, 12'h0, term_pkg::CTRL_REG_ENABLE};
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      set_pixels_idle();
      @(posedge resetb);
      bus_access(1'b0, {term_pkg::TERM_CONTROL, 12'h0, term_pkg::CTRL_REG_TERM_ID}, '0);
      // fill the whole table, its contents come up unknown
      for (int i = 0; i < 256; i++) begin
         adr = {term_pkg::TERM_LOOKUP_MAP, 8'(take_bits(8)), 8'(i)};
         bus_access(1'b1, adr, 16'(take_bits(16)));
      end
      repeat (N_RW) begin
         adr = {term_pkg::TERM_LOOKUP_MAP, 8'(take_bits(8)), 8'(take_bits(8))};
         bus_access(1'b1, adr, 16'(take_bits(16)));
         bus_access(1'b0, adr, '0);
      end
      bus_access(1'b1, ctrl_en, 16'h0001);
      bus_access(1'b0, ctrl_en, '0);
      stream_pixels(N_PHASE_PIX);
      bus_access(1'b1, ctrl_en, 16'h0000);
      bus_access(1'b0, ctrl_en, '0);
      stream_pixels(N_PHASE_PIX);
      bus_access(1'b1, ctrl_en, 16'h0001);
      // unknown terminal, nothing may change
      term = 16'(take_bits(16));
      if (term == term_pkg::TERM_LOOKUP_MAP || term == term_pkg::TERM_CONTROL) begin
         term = term ^ 16'h8000;
      end
      bus_access(1'b1, {term, 12'h0, term_pkg::CTRL_REG_ENABLE}, 16'h0000);
      bus_access(1'b0, {term, 12'h0, term_pkg::CTRL_REG_ENABLE}, '0);
      bus_access(1'b0, ctrl_en, '0);
      adr = {term_pkg::TERM_LOOKUP_MAP, 8'h00, 8'(take_bits(8))};
      bus_access(1'b1, {term, adr[15:0]}, 16'(take_bits(16)));
      bus_access(1'b0, adr, '0);
      stream_pixels(N_PHASE_PIX);
      repeat (4) @(posedge di_clk);
      $display("run complete, %0d errors", error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #((N_BUS + N_PIX) * MARGIN * 8);
      $display("timeout: run did not finish within %0d cycles", (N_BUS + N_PIX) * MARGIN);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* pixel_lut_top.f */
term_pkg.sv
pixel_pkg.sv
lut_ram.sv
term_bus_slave.sv
lookup_map.sv
pixel_lut_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_pixel_lut_top.sv

/* Bender.yml */
package:
  name: pixel_lut_top

sources:
  - term_pkg.sv
  - pixel_pkg.sv
  - lut_ram.sv
  - term_bus_slave.sv
  - lookup_map.sv
  - pixel_lut_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_pixel_lut_top.sv
